/* build.f */
design/corrPkg.sv
design/logBusIf.sv
design/logConverter.sv
design/antilogConverter.sv
design/descriptorBank.sv
design/windowConverter.sv
design/processingElement.sv
design/correlatorRow.sv
design/logCorrelator.sv
testbench/corrTestbench.sv

/* design/antilogConverter.sv */
`timescale 1ns/1ps

module antilogConverter (
	input  logic [corrPkg::expWidth+corrPkg::fracWidth-1:0] magnitude,
	output logic [corrPkg::productWidth-1:0]                product
);

	logic [corrPkg::expWidth-1:0] intPart;
	logic [corrPkg::fracWidth-1:0] fracPart;

	// mantissa with its hidden one, shifted by the integer part
	logic [corrPkg::fracWidth+2**corrPkg::expWidth-1:0] mantissa;
	logic [corrPkg::fracWidth+2**corrPkg::expWidth-1:0] scaled;

	always_comb begin
		intPart = magnitude[corrPkg::expWidth+corrPkg::fracWidth-1:corrPkg::fracWidth];
		fracPart = magnitude[corrPkg::fracWidth-1:0];
	end

	always_comb begin
		mantissa = '0;
		mantissa[corrPkg::fracWidth] = 1'b1;
		mantissa[corrPkg::fracWidth-1:0] = fracPart;
	end

	// 1 << e with the top e fraction bits filled in below it
	always_comb begin
		scaled = mantissa << intPart;
	end

	// integer part only, truncated to the product width
	always_comb begin
		product = scaled[corrPkg::fracWidth +: corrPkg::productWidth];
	end

endmodule

/* design/corrPkg.sv */
package corrPkg;

	// row geometry and datapath widths
	localparam int numTaps = 4;
	localparam int pixelWidth = 8;
	localparam int expWidth = 5;
	localparam int fracWidth = 27;
	localparam int productWidth = 16;
	localparam int accWidth = 20;

	// log word as the converter builds it
	typedef struct packed {
		logic isZero;
		logic sign;
		logic [expWidth-1:0] exponent;
		logic [fracWidth-1:0] fraction;
	} logFields_t;

	// same bits, exponent and fraction taken as one fixed-point number
	typedef struct packed {
		logic isZero;
		logic sign;
		logic [expWidth+fracWidth-1:0] magnitude;
	} logMag_t;

	typedef union packed {
		logFields_t fields;
		logMag_t mag;
	} logWord_u;

endpackage

/* design/correlatorRow.sv */
`timescale 1ns/1ps

module correlatorRow (
	input  logic                                clk,
	input  logic                                rst,
	logBusIf.row                                bus,
	output logic signed [corrPkg::accWidth-1:0] corrSum,
	output logic                                corrValid
);

	logic signed [corrPkg::accWidth-1:0] accChain [corrPkg::numTaps+1];
	corrPkg::logWord_u winChain [corrPkg::numTaps+1];
	logic [$clog2(corrPkg::numTaps+1)-1:0] fillCount;
	logic shift;
	logic shiftDly;
	logic rowFull;

	assign shift = bus.winValid;
	assign rowFull = (fillCount == corrPkg::numTaps);

	// head of both chains
	assign accChain[0] = '0;
	assign winChain[0] = bus.winLog;

	genvar k;
	generate
		for (k = 0; k < corrPkg::numTaps; k++) begin : g_tap
			processingElement i_processingElement (
				.clk    (clk),
				.rst    (rst),
				.coef   (bus.coef[k]),
				.winIn  (winChain[k]),
				.shift  (shift),
				.accIn  (accChain[k]),
				.accOut (accChain[k+1]),
				.winOut (winChain[k+1])
			);
		end
	endgenerate

	// pixels held in the row, saturates once full
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fillCount <= '0;
		end else if (shift && !rowFull) begin
			fillCount <= fillCount + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shiftDly <= 1'b0;
		end else begin
			shiftDly <= shift;
		end
	end

	// sum settles one cycle after the taps shift
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			corrSum <= '0;
			corrValid <= 1'b0;
		end else begin
			corrValid <= shiftDly && rowFull && bus.descReady;
			if (shiftDly) begin
				corrSum <= accChain[corrPkg::numTaps];
			end
		end
	end

endmodule

/* design/descriptorBank.sv */
`timescale 1ns/1ps

module descriptorBank (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] descData,
	input  logic        descLoad,
	logBusIf.bank       bus
);

	logic [corrPkg::pixelWidth-1:0] coefByte [corrPkg::numTaps];
	logic [corrPkg::pixelWidth-1:0] coefAbs [corrPkg::numTaps];
	logic coefNeg [corrPkg::numTaps];
	corrPkg::logWord_u coefLog [corrPkg::numTaps];

	genvar k;
	generate
		for (k = 0; k < corrPkg::numTaps; k++) begin : g_coef
			// tap 0 takes the top byte
			assign coefByte[k] = descData[31-k*corrPkg::pixelWidth -: corrPkg::pixelWidth];
			assign coefNeg[k] = coefByte[k][corrPkg::pixelWidth-1];
			// two's complement magnitude, -128 becomes 8'h80
			assign coefAbs[k] = coefNeg[k] ? -coefByte[k] : coefByte[k];

			logConverter i_logConverter (
				.value      (coefAbs[k]),
				.isNegative (coefNeg[k]),
				.logOut     (coefLog[k])
			);
		end
	endgenerate

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < corrPkg::numTaps; i++) begin
				bus.coef[i] <= '0;
			end
		end else if (descLoad) begin
			for (int i = 0; i < corrPkg::numTaps; i++) begin
				bus.coef[i] <= coefLog[i];
			end
		end
	end

	// sticky once the first descriptor is in
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bus.descReady <= 1'b0;
		end else if (descLoad) begin
			bus.descReady <= 1'b1;
		end
	end

endmodule

/* design/logBusIf.sv */
`timescale 1ns/1ps

interface logBusIf;

	// coefficient bank contents
	corrPkg::logWord_u coef [corrPkg::numTaps];
	logic descReady;

	// converted window pixel
	corrPkg::logWord_u winLog;
	logic winValid;

	modport bank (
		output coef,
		output descReady
	);

	modport window (
		output winLog,
		output winValid
	);

	modport row (
		input coef,
		input descReady,
		input winLog,
		input winValid
	);

endinterface

/* design/logConverter.sv */
`timescale 1ns/1ps

module logConverter (
	input  logic [corrPkg::pixelWidth-1:0] value,
	input  logic                           isNegative,
	output corrPkg::logWord_u              logOut
);

	logic hasHigh4;
	logic hasHigh2;
	logic hasHigh1;
	logic [corrPkg::pixelWidth-1:0] stage1;
	logic [corrPkg::pixelWidth-1:0] stage2;
	logic [corrPkg::pixelWidth-1:0] normalized;

	// leading-one search, halving the window at each stage
	always_comb begin
		hasHigh4 = |value[7:4];
		if (hasHigh4) begin
			stage1 = value;
		end else begin
			stage1 = value << 4;
		end

		hasHigh2 = |stage1[7:6];
		if (hasHigh2) begin
			stage2 = stage1;
		end else begin
			stage2 = stage1 << 2;
		end

		hasHigh1 = stage2[7];
		if (hasHigh1) begin
			normalized = stage2;
		end else begin
			normalized = stage2 << 1;
		end
	end

	// leading one now sits at the top bit of normalized
	always_comb begin
		logOut = '0;
		logOut.fields.sign = isNegative;
		if (value == '0) begin
			logOut.fields.isZero = 1'b1;
		end else begin
			logOut.fields.isZero = 1'b0;
			logOut.fields.exponent = {
				{(corrPkg::expWidth-3){1'b0}},
				hasHigh4,
				hasHigh2,
				hasHigh1
			};
			// bits below the leading one, left-aligned
			logOut.fields.fraction = {
				normalized[corrPkg::pixelWidth-2:0],
				{(corrPkg::fracWidth-corrPkg::pixelWidth+1){1'b0}}
			};
		end
	end

endmodule

/* design/logCorrelator.sv */
`timescale 1ns/1ps

module logCorrelator (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [31:0]                         descData,
	input  logic                                descLoad,
	input  logic [corrPkg::pixelWidth-1:0]      winPixel,
	input  logic                                pixelValid,
	output logic signed [corrPkg::accWidth-1:0] corrSum,
	output logic                                corrValid
);

	logBusIf logBus ();

	// coefficient side
	descriptorBank i_descriptorBank (
		.clk      (clk),
		.rst      (rst),
		.descData (descData),
		.descLoad (descLoad),
		.bus      (logBus.bank)
	);

	// pixel side
	windowConverter i_windowConverter (
		.clk        (clk),
		.rst        (rst),
		.winPixel   (winPixel),
		.pixelValid (pixelValid),
		.bus        (logBus.window)
	);

	correlatorRow i_correlatorRow (
		.clk       (clk),
		.rst       (rst),
		.bus       (logBus.row),
		.corrSum   (corrSum),
		.corrValid (corrValid)
	);

endmodule

/* design/processingElement.sv */
`timescale 1ns/1ps

module processingElement (
	input  logic                                clk,
	input  logic                                rst,
	input  corrPkg::logWord_u                   coef,
	input  corrPkg::logWord_u                   winIn,
	input  logic                                shift,
	input  logic signed [corrPkg::accWidth-1:0] accIn,
	output logic signed [corrPkg::accWidth-1:0] accOut,
	output corrPkg::logWord_u                   winOut
);

	corrPkg::logWord_u winReg;
	logic [corrPkg::expWidth+corrPkg::fracWidth-1:0] logSum;
	logic [corrPkg::productWidth-1:0] product;
	logic signed [corrPkg::accWidth-1:0] term;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			winReg <= '0;
		end else if (shift) begin
			winReg <= winIn;
		end
	end

	assign winOut = winReg;

	// multiply in the log domain
	assign logSum = coef.mag.magnitude + winReg.mag.magnitude;

	antilogConverter i_antilogConverter (
		.magnitude (logSum),
		.product   (product)
	);

	always_comb begin
		if (coef.mag.isZero || winReg.mag.isZero) begin
			term = '0;
		end else begin
			term = {{(corrPkg::accWidth-corrPkg::productWidth){1'b0}}, product};
		end

		// opposite signs subtract
		if (coef.mag.sign ^ winReg.mag.sign) begin
			accOut = accIn - term;
		end else begin
			accOut = accIn + term;
		end
	end

endmodule

/* design/windowConverter.sv */
`timescale 1ns/1ps

module windowConverter (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [corrPkg::pixelWidth-1:0] winPixel,
	input  logic                           pixelValid,
	logBusIf.window                        bus
);

	corrPkg::logWord_u pixelLog;

	// window pixels are unsigned
	logConverter i_logConverter (
		.value      (winPixel),
		.isNegative (1'b0),
		.logOut     (pixelLog)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bus.winLog <= '0;
		end else if (pixelValid) begin
			bus.winLog <= pixelLog;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bus.winValid <= 1'b0;
		end else begin
			bus.winValid <= pixelValid;
		end
	end

endmodule

/* testbench/corrTestbench.sv */
`timescale 1ns/1ps

module corrTestbench;

	logic clk = 1'b0;
	logic rst;
	logic [31:0] descData;
	logic descLoad;
	logic [corrPkg::pixelWidth-1:0] winPixel;
	logic pixelValid;
	logic signed [corrPkg::accWidth-1:0] corrSum;
	logic corrValid;

	string testName = "init";
	integer seed = 32'h46d;
	int cycleCount = 0;
	int pulseCount = 0;

	// model of the row state updated on the same edges as the DUT
	logic [7:0] modelCoef [corrPkg::numTaps];
	logic [7:0] modelTaps [corrPkg::numTaps];
	int modelFill = 0;
	bit modelReady = 0;
	bit stage1Valid = 0;
	bit stage2Valid = 0;
	logic [7:0] stage1Pixel;
	bit dueValid = 0;
	logic signed [corrPkg::accWidth-1:0] expectQ [$];

	logCorrelator i_logCorrelator (
		.clk        (clk),
		.rst        (rst),
		.descData   (descData),
		.descLoad   (descLoad),
		.winPixel   (winPixel),
		.pixelValid (pixelValid),
		.corrSum    (corrSum),
		.corrValid  (corrValid)
	);

	always #4 clk = ~clk;

	// exponent is the leading one and fraction the bits below it left-aligned
	function automatic logic [31:0] logValue(input logic [7:0] m);
		int e;
		logic [31:0] frac;
		e = 0;
		for (int i = 0; i < 8; i++) begin
			if (m[i]) e = i;
		end
		frac = ((32'(m) & ((32'd1 << e) - 1)) << (27 - e));
		return {e[4:0], frac[26:0]};
	endfunction

	// Mitchell product of a signed coefficient and an unsigned pixel
	function automatic logic signed [corrPkg::accWidth-1:0] mulRef(
		input logic [7:0] coefByte,
		input logic [7:0] pixel
	);
		logic [7:0] coefMag;
		logic [31:0] logSum;
		logic [63:0] scaled;
		logic signed [corrPkg::accWidth-1:0] term;
		coefMag = coefByte[7] ? -coefByte : coefByte;
		if (coefMag == 8'd0 || pixel == 8'd0) return '0;
		logSum = logValue(coefMag) + logValue(pixel);
		scaled = ((64'd1 << 27) | 64'(logSum[26:0])) << logSum[31:27];
		term = {4'd0, scaled[27 +: 16]};
		return coefByte[7] ? -term : term;
	endfunction

	function automatic logic signed [corrPkg::accWidth-1:0] sumRef();
		logic signed [corrPkg::accWidth-1:0] acc;
		acc = '0;
		for (int k = 0; k < corrPkg::numTaps; k++) begin
			acc = acc + mulRef(modelCoef[k], modelTaps[k]);
		end
		return acc;
	endfunction

	task automatic checkSum(input logic signed [corrPkg::accWidth-1:0] expected,
			input logic signed [corrPkg::accWidth-1:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: corrSum expected %0d, actual %0d", testName, expected, actual);
			$display("Simulation failed");
			$fatal(1, "corrSum mismatch");
		end
	endtask

	task automatic checkValid(input bit expected, input bit actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: corrValid expected %0b, actual %0b", testName, expected, actual);
			$display("Simulation failed");
			$fatal(1, "corrValid mismatch");
		end
	endtask

	task automatic checkCount(input int expected, input int actual);
		if (expected != actual) begin
			$display("[FAIL] %s: pulse count expected %0d, actual %0d", testName, expected, actual);
			$display("Simulation failed");
			$fatal(1, "pulse count mismatch");
		end
	endtask

	// inputs as sampled by the DUT with sums due two edges after a pixel
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			dueValid = 1'b0;
			expectQ.delete();
			stage1Valid = 1'b0;
			stage2Valid = 1'b0;
			modelFill = 0;
			modelReady = 1'b0;
		end else begin
			dueValid = stage2Valid && modelFill == corrPkg::numTaps && modelReady;
			if (dueValid) expectQ.push_back(sumRef());
			if (stage1Valid) begin
				for (int k = corrPkg::numTaps - 1; k > 0; k--) begin
					modelTaps[k] = modelTaps[k-1];
				end
				modelTaps[0] = stage1Pixel;
				if (modelFill < corrPkg::numTaps) modelFill++;
			end
			stage2Valid = stage1Valid;
			stage1Valid = pixelValid;
			stage1Pixel = winPixel;
			if (descLoad) begin
				for (int k = 0; k < corrPkg::numTaps; k++) begin
					modelCoef[k] = descData[31-8*k -: 8];
				end
				modelReady = 1'b1;
			end
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			checkValid(dueValid, corrValid);
			if (corrValid) begin
				pulseCount++;
				checkSum(expectQ.pop_front(), corrSum);
			end
		end
	end

	// limit well above the length of all tests
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= 2000) begin
			$display("Simulation timed out after %0d cycles", cycleCount);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	task automatic driveCycle(input bit valid, input logic [7:0] pixel,
			input bit load, input logic [31:0] desc);
		@(posedge clk);
		pixelValid <= valid;
		winPixel <= pixel;
		descLoad <= load;
		descData <= desc;
	endtask

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		pixelValid <= 1'b0;
		descLoad <= 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	endtask

	// four idle cycles cover the two-edge latency of the last sum
	task automatic drainRow();
		repeat (4) driveCycle(1'b0, 8'd0, 1'b0, 32'd0);
	endtask

	task automatic testReset();
		testName = "testReset";
		applyReset();
		@(negedge clk);
		checkValid(1'b0, corrValid);
		checkSum('0, corrSum);
		pulseCount = 0;
		for (int i = 0; i < 6; i++) driveCycle(1'b1, 8'(17 * i + 3), 1'b0, 32'd0);
		drainRow();
		checkCount(0, pulseCount);
	endtask

	task automatic testBasicRow();
		logic [7:0] pixels [10] = '{8'd1, 8'd2, 8'd3, 8'd5, 8'd13, 8'd34,
			8'd89, 8'd128, 8'd200, 8'd255};
		testName = "testBasicRow";
		applyReset();
		driveCycle(1'b0, 8'd0, 1'b1, 32'h03_11_40_7F);
		pulseCount = 0;
		foreach (pixels[i]) driveCycle(1'b1, pixels[i], 1'b0, 32'd0);
		drainRow();
		checkCount(7, pulseCount);
	endtask

	task automatic testSignsAndZeros();
		logic [7:0] pixels [8] = '{8'd0, 8'd255, 8'd1, 8'd0, 8'd17, 8'd128, 8'd0, 8'd99};
		testName = "testSignsAndZeros";
		driveCycle(1'b0, 8'd0, 1'b1, 32'h80_00_F3_7F);
		pulseCount = 0;
		foreach (pixels[i]) driveCycle(1'b1, pixels[i], 1'b0, 32'd0);
		drainRow();
		checkCount(8, pulseCount);
	endtask

	task automatic testStreamGaps();
		int sent;
		testName = "testStreamGaps";
		sent = 0;
		driveCycle(1'b0, 8'd0, 1'b1, $random(seed));
		pulseCount = 0;
		while (sent < 40) begin
			if ($random(seed) & 1) begin
				driveCycle(1'b1, 8'($random(seed)), 1'b0, 32'd0);
				sent++;
			end else begin
				driveCycle(1'b0, 8'd0, 1'b0, 32'd0);
			end
		end
		drainRow();
		checkCount(40, pulseCount);
	endtask

	task automatic testReload();
		testName = "testReload";
		driveCycle(1'b0, 8'd0, 1'b1, 32'h7F_40_20_10);
		pulseCount = 0;
		for (int i = 0; i < 12; i++) begin
			// new descriptor lands with pixel six
			driveCycle(1'b1, 8'(23 * i + 7), i == 6, 32'hC0_05_81_7F);
		end
		drainRow();
		checkCount(12, pulseCount);
	endtask

	initial begin
		rst = 1'b1;
		descData = '0;
		descLoad = 1'b0;
		winPixel = '0;
		pixelValid = 1'b0;
		testReset();
		testBasicRow();
		testSignsAndZeros();
		testStreamGaps();
		testReload();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
